// File: sim.f
source/cache_pkg.sv
source/cache_tag_array.sv
source/cache_data_array.sv
source/cache_fill_control.sv
source/memory_system.sv
source/main_memory.sv
source/memory_subsystem_top.sv
bench/bench_clock_gen.sv
bench/memory_subsystem_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, then look for the fail message in the log
verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
    --top-module memory_subsystem_tb -f sim.f -o memory_subsystem_sim > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/memory_subsystem_sim > sim.log 2>&1
cat sim.log

grep -q "Simulation failed" sim.log && { echo "Result: FAIL"; exit 1; }
grep -q "Simulation completed successfully" sim.log \
    || { echo "Result: FAIL, no result line"; exit 1; }
echo "Result: PASS"

// File: bench/memory_subsystem_tb.sv
// Directed testbench for the memory subsystem; preloads main memory, then checks hits, fills and writes
module memory_subsystem_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD    = 10;
    localparam int MEM_LATENCY   = 3;
    localparam int MEM_ADDR_BITS = 10;
    localparam int MEM_WORDS     = 2**MEM_ADDR_BITS;
    localparam int FILL_CYCLES   = cache_pkg::LINE_WORDS * (MEM_LATENCY + 3) + 4; // Grant held high
    localparam int STALL_CYCLES  = FILL_CYCLES + 8;              // Grant held low past a whole fill
    localparam int NUM_TESTS     = 6;
    localparam int WATCHDOG_CYCLES =
        16 + MEM_WORDS + NUM_TESTS * (4 * FILL_CYCLES + STALL_CYCLES + 40);

    logic             clk, reset;
    logic             enable, proceed, on_chip_wr, load_en;
    cache_pkg::addr_t on_chip_memory_address, load_address;
    cache_pkg::word_t on_chip_memory_data, load_data, data_out;
    logic             hit, fsm_busy;

    // Reference state
    cache_pkg::word_t shadow_mem   [MEM_WORDS];          // Main memory contents
    cache_pkg::word_t cache_model  [cache_pkg::NUM_LINES * cache_pkg::LINE_WORDS];
    cache_pkg::tag_t  resident_tag [cache_pkg::NUM_LINES];
    logic [cache_pkg::NUM_LINES-1:0] resident_valid;
    logic [31:0]      lfsr_state;
    int               errors, checks;

    bench_clock_gen u_clock (.clk(clk), .reset(reset));

    memory_subsystem_top #(
        .MEM_LATENCY   (MEM_LATENCY),
        .MEM_ADDR_BITS (MEM_ADDR_BITS)
    ) dut0 (
        .clk                    (clk),
        .reset                  (reset),
        .enable                 (enable),
        .proceed                (proceed),
        .on_chip_wr             (on_chip_wr),
        .on_chip_memory_address (on_chip_memory_address),
        .on_chip_memory_data    (on_chip_memory_data),
        .data_out               (data_out),
        .hit                    (hit),
        .fsm_busy               (fsm_busy),
        .load_en                (load_en),
        .load_address           (load_address),
        .load_data              (load_data)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);    // Galois, taps 32,22,2,1
    endfunction

    task automatic random_word(output cache_pkg::word_t w);
        for (int i = 0; i < 16; i++) begin
            w          = {w[14:0], lfsr_state[0]};  // One bit per step
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    function automatic cache_pkg::word_t memory_word(input cache_pkg::addr_t addr);
        return shadow_mem[addr[MEM_ADDR_BITS-1:0]];     // Upper bits alias
    endfunction

    function automatic logic expect_hit(input cache_pkg::addr_t addr);
        return resident_valid[addr[5:2]] && (resident_tag[addr[5:2]] == addr[15:6]);
    endfunction

    // Direct-mapped rule; a fill replaces the whole line and drops earlier writes
    function automatic void model_fill(input cache_pkg::addr_t addr);
        cache_pkg::index_t idx;
        idx                 = addr[5:2];
        resident_valid[idx] = 1'b1;
        resident_tag[idx]   = addr[15:6];
        for (int w = 0; w < cache_pkg::LINE_WORDS; w++) begin
            cache_model[{idx, 2'(w)}] = memory_word({addr[15:2], 2'(w)});
        end
    endfunction

    task automatic drive_access(input cache_pkg::addr_t addr, input logic wr,
                                input cache_pkg::word_t data);
        @(posedge clk);
        enable                 <= 1'b1;
        on_chip_wr             <= wr;
        on_chip_memory_address <= addr;
        on_chip_memory_data    <= data;
    endtask

    task automatic preload_memory();
        cache_pkg::word_t w;
        for (int a = 0; a < MEM_WORDS; a++) begin
            random_word(w);
            shadow_mem[a] = w;
            @(posedge clk);
            load_en      <= 1'b1;
            load_address <= cache_pkg::addr_t'(a);
            load_data    <= w;
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    // Called just after a negedge with fsm_busy seen high
    task automatic wait_fill_done(input int bound);
        int cycles;
        cycles = 0;
        while (fsm_busy && cycles < bound) begin
            @(negedge clk);
            cycles++;
        end
        if (fsm_busy) begin
            errors++;
            $display("Line fill still busy after %0d cycles at %0t", bound, $time);
        end
    endtask

    task automatic read_word(input cache_pkg::addr_t addr);
        logic exp_hit;
        exp_hit = expect_hit(addr);
        drive_access(addr, 1'b0, '0);
        @(negedge clk);
        check_value("hit", hit, exp_hit);
        if (!exp_hit) begin
            @(negedge clk);                         // Miss taken on the edge between
            check_value("fsm_busy", fsm_busy, 1'b1);
            wait_fill_done(FILL_CYCLES);
            model_fill(addr);
            check_value("hit", hit, 1'b1);          // First cycle after busy falls
        end
        check_value("data_out", data_out, cache_model[addr[5:0]]);
    endtask

    task automatic write_word(input cache_pkg::addr_t addr, input cache_pkg::word_t data);
        logic exp_hit;
        exp_hit = expect_hit(addr);
        drive_access(addr, 1'b1, data);
        @(negedge clk);
        check_value("hit", hit, exp_hit);
        if (exp_hit) cache_model[addr[5:0]] = data;    // Lands on the next edge
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////
    task automatic after_reset();
        @(negedge clk);
        check_value("fsm_busy", fsm_busy, 1'b0);
        read_word(16'h0010);                    // Cold cache so this misses
    endtask

    task automatic read_miss_fill();
        read_word(16'h0126);                    // Miss in the middle of the line
        for (int w = 0; w < cache_pkg::LINE_WORDS; w++) begin
            read_word(16'h0124 + 16'(w));
        end
    endtask

    task automatic write_hit_update();
        cache_pkg::word_t w;
        random_word(w);
        if (w == cache_model[6'h25]) w = ~w;    // Make the write visible
        write_word(16'h0125, w);
        read_word(16'h0125);
        read_word(16'h0124);                    // Neighbors unchanged
        read_word(16'h0126);
    endtask

    task automatic eviction_refill();
        read_word(16'h81E5);                    // Index 9, other tag, aliases 0x1E5
        read_word(16'h0125);                    // Misses again and returns the memory value
        read_word(16'h0127);
    endtask

    task automatic grant_stall();
        @(posedge clk);
        proceed <= 1'b0;
        drive_access(16'h02C8, 1'b0, '0);
        @(negedge clk);
        check_value("hit", hit, 1'b0);
        for (int i = 0; i < STALL_CYCLES; i++) begin
            @(negedge clk);
            check_value("fsm_busy", fsm_busy, 1'b1);   // Parked in wait_grant
        end
        @(posedge clk);
        proceed <= 1'b1;
        @(negedge clk);
        wait_fill_done(FILL_CYCLES);
        model_fill(16'h02C8);
        check_value("hit", hit, 1'b1);
        check_value("data_out", data_out, cache_model[6'h08]);
        read_word(16'h02CB);
    endtask

    task automatic enable_low_idle();
        @(posedge clk);
        enable                 <= 1'b0;
        on_chip_wr             <= 1'b1;
        on_chip_memory_address <= 16'h0125;     // Resident line
        on_chip_memory_data    <= ~cache_model[6'h25];
        repeat (3) begin
            @(negedge clk);
            check_value("fsm_busy", fsm_busy, 1'b0);
        end
        @(posedge clk);
        on_chip_memory_address <= 16'h03F0;     // Not resident yet no fill starts
        repeat (4) begin
            @(negedge clk);
            check_value("fsm_busy", fsm_busy, 1'b0);
        end
        read_word(16'h0125);
        @(posedge clk);
        enable <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Sequence and report
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        enable                 = 1'b0;
        proceed                = 1'b1;
        on_chip_wr             = 1'b0;
        on_chip_memory_address = '0;
        on_chip_memory_data    = '0;
        load_en                = 1'b0;
        load_address           = '0;
        load_data              = '0;
        errors                 = 0;
        checks                 = 0;
        lfsr_state             = 32'hb886;
        resident_valid         = '0;

        @(negedge reset);
        preload_memory();
        after_reset();
        read_miss_fill();
        write_hit_update();
        eviction_refill();
        grant_stall();
        enable_low_idle();
        repeat (2) @(posedge clk);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Ends a hung run
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: bench/bench_clock_gen.sv
// Testbench clock and reset source; 10 ns clock with synchronous reset held for the first cycles
module bench_clock_gen #(
    parameter int RESET_CYCLES = 16     // Cycles with reset high
) (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;          // 10 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;                  // Released on a rising edge
    end

endmodule

// File: source/memory_subsystem_top.sv
// Top of the memory subsystem; the cache wrapper connected to the main memory model
module memory_subsystem_top #(
    parameter int MEM_LATENCY   = 3,    // Main memory read latency
    parameter int MEM_ADDR_BITS = 10    // Main memory depth in address bits
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             enable,
    input  logic             proceed,
    input  logic             on_chip_wr,
    input  cache_pkg::addr_t on_chip_memory_address,
    input  cache_pkg::word_t on_chip_memory_data,
    output cache_pkg::word_t data_out,
    output logic             hit,
    output logic             fsm_busy,
    input  logic             load_en,           // Preload port
    input  cache_pkg::addr_t load_address,
    input  cache_pkg::word_t load_data
);

    cache_pkg::addr_t off_chip_memory_address;
    cache_pkg::word_t off_chip_memory_data;
    logic             mem_read;
    logic             memory_data_valid;

    memory_system u_memory_system (
        .clk                     (clk),
        .reset                   (reset),
        .enable                  (enable),
        .proceed                 (proceed),
        .on_chip_wr              (on_chip_wr),
        .on_chip_memory_address  (on_chip_memory_address),
        .on_chip_memory_data     (on_chip_memory_data),
        .off_chip_memory_data    (off_chip_memory_data),
        .memory_data_valid       (memory_data_valid),
        .off_chip_memory_address (off_chip_memory_address),
        .mem_read                (mem_read),
        .fsm_busy                (fsm_busy),
        .data_out                (data_out),
        .hit                     (hit)
    );

    main_memory #(
        .MEM_LATENCY   (MEM_LATENCY),
        .MEM_ADDR_BITS (MEM_ADDR_BITS)
    ) u_main_memory (
        .clk          (clk),
        .reset        (reset),
        .load_en      (load_en),
        .load_address (load_address),
        .load_data    (load_data),
        .mem_read     (mem_read),
        .address      (off_chip_memory_address),
        .data         (off_chip_memory_data),
        .data_valid   (memory_data_valid)
    );

endmodule

// File: source/main_memory.sv
// Word-addressed main memory model with fixed read latency and a preload port
module main_memory #(
    parameter int MEM_LATENCY   = 3,    // mem_read to data_valid, in cycles
    parameter int MEM_ADDR_BITS = 10    // Implemented address bits
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             load_en,       // Preload write
    input  cache_pkg::addr_t load_address,
    input  cache_pkg::word_t load_data,
    input  logic             mem_read,      // Read request, one cycle
    input  cache_pkg::addr_t address,       // Read address
    output cache_pkg::word_t data,          // Read word, with data_valid
    output logic             data_valid     // One-cycle strobe
);

    cache_pkg::word_t mem [2**MEM_ADDR_BITS];   // Upper address bits alias

    logic [MEM_LATENCY-1:0] valid_pipe;         // Read in flight per stage
    cache_pkg::addr_t       addr_pipe [MEM_LATENCY];

    // Preload from outside
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_address[MEM_ADDR_BITS-1:0]] <= load_data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Latency pipeline
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe[0] <= mem_read;
            for (int i = 1; i < MEM_LATENCY; i++) begin
                valid_pipe[i] <= valid_pipe[i-1];   // Shift toward the MSB
            end
        end
    end

    always_ff @(posedge clk) begin
        addr_pipe[0] <= address;
        for (int i = 1; i < MEM_LATENCY; i++) begin
            addr_pipe[i] <= addr_pipe[i-1];
        end
    end

    // Word is read at the last stage
    assign data_valid = valid_pipe[MEM_LATENCY-1];
    assign data       = mem[addr_pipe[MEM_LATENCY-1][MEM_ADDR_BITS-1:0]];

endmodule

// File: source/memory_system.sv
// Cache wrapper; joins the tag and data arrays with the fill FSM and steers address and data
module memory_system (
    input  logic             clk,
    input  logic             reset,
    input  logic             enable,                  // Processor access this cycle
    input  logic             proceed,                 // Main memory grant
    input  logic             on_chip_wr,              // Processor write
    input  cache_pkg::addr_t on_chip_memory_address,  // Processor address
    input  cache_pkg::word_t on_chip_memory_data,     // Processor write data
    input  cache_pkg::word_t off_chip_memory_data,    // Main memory read data
    input  logic             memory_data_valid,       // Main memory data strobe
    output cache_pkg::addr_t off_chip_memory_address, // Main memory read address
    output logic             mem_read,                // Main memory read request
    output logic             fsm_busy,                // Stall to processor
    output cache_pkg::word_t data_out,                // Cache read data
    output logic             hit                      // Cache hit
);

    cache_pkg::addr_t cache_addr;       // Address given to both arrays
    cache_pkg::word_t cache_data_in;
    logic             data_write;
    logic             miss;

    cache_pkg::addr_t ctrl_cache_address;
    cache_pkg::word_t ctrl_data;
    logic             ctrl_write_data;
    logic             ctrl_write_tag;

    ////////////////////////////////////////////////////////////////////////////
    // Steering while the controller owns the arrays
    ////////////////////////////////////////////////////////////////////////////
    assign cache_addr    = fsm_busy ? ctrl_cache_address : on_chip_memory_address;
    assign cache_data_in = fsm_busy ? ctrl_data : on_chip_memory_data;
    assign data_write    = fsm_busy ? ctrl_write_data : (enable & on_chip_wr & hit); // Hit only
    assign miss          = enable & ~fsm_busy & ~hit;

    cache_tag_array u_tags (
        .clk       (clk),
        .reset     (reset),
        .addr      (cache_addr),
        .tag_write (ctrl_write_tag),
        .hit       (hit)
    );

    cache_data_array u_data (
        .clk        (clk),
        .addr       (cache_addr),
        .data_in    (cache_data_in),
        .data_write (data_write),
        .data_out   (data_out)
    );

    cache_fill_control u_fill (
        .clk                  (clk),
        .reset                (reset),
        .miss                 (miss),
        .proceed              (proceed),
        .miss_address         (on_chip_memory_address),
        .memory_data          (off_chip_memory_data),
        .memory_data_valid    (memory_data_valid),
        .fsm_busy             (fsm_busy),
        .mem_read             (mem_read),
        .main_memory_address  (off_chip_memory_address),
        .cache_memory_address (ctrl_cache_address),
        .memory_data_out      (ctrl_data),
        .write_data_array     (ctrl_write_data),
        .write_tag_array      (ctrl_write_tag)
    );

endmodule

// File: source/cache_fill_control.sv
// Line fill FSM; on a miss it fetches four words from main memory, then writes the tag
module cache_fill_control (
    input  logic             clk,
    input  logic             reset,
    input  logic             miss,                 // Qualified miss from the wrapper
    input  logic             proceed,              // Bus grant level
    input  cache_pkg::addr_t miss_address,         // Processor address that missed
    input  cache_pkg::word_t memory_data,          // Word from main memory
    input  logic             memory_data_valid,    // One-cycle data strobe
    output logic             fsm_busy,             // Stall to processor
    output logic             mem_read,             // Read request to main memory
    output cache_pkg::addr_t main_memory_address,  // Word being fetched
    output cache_pkg::addr_t cache_memory_address, // Word being filled in the cache
    output cache_pkg::word_t memory_data_out,      // Fill data to data array
    output logic             write_data_array,     // Fill word strobe
    output logic             write_tag_array       // Tag and valid strobe
);

    cache_pkg::fill_state_t state, next_state;
    cache_pkg::addr_t       line_base;     // Latched line address, offset zero
    cache_pkg::offset_t     word_cnt;      // Word of the line in flight
    logic                   last_word;

    assign last_word = (word_cnt == cache_pkg::offset_t'(cache_pkg::LINE_WORDS - 1));

    ////////////////////////////////////////////////////////////////////////////
    // State register and word counter
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= cache_pkg::idle;
            word_cnt <= '0;
        end else begin
            state <= next_state;
            if (state == cache_pkg::idle) begin
                word_cnt <= '0;                         // Fill starts at word 0
            end else if (state == cache_pkg::wait_data && memory_data_valid && !last_word) begin
                word_cnt <= word_cnt + 1'b1;            // Step to the next word
            end
        end
    end

    // Line base captured when the miss is accepted
    always_ff @(posedge clk) begin
        if (state == cache_pkg::idle && miss) begin
            line_base <= {miss_address[15:2], 2'b00};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Next state
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        next_state = state;
        case (state)
            cache_pkg::idle:       if (miss)    next_state = cache_pkg::wait_grant;
            cache_pkg::wait_grant: if (proceed) next_state = cache_pkg::request;
            cache_pkg::request:                 next_state = cache_pkg::wait_data;
            cache_pkg::wait_data: begin
                if (memory_data_valid) begin
                    next_state = last_word ? cache_pkg::finish : cache_pkg::wait_grant;
                end
            end
            cache_pkg::finish:                  next_state = cache_pkg::idle;
            default:                            next_state = cache_pkg::idle;
        endcase
    end

    // Outputs decoded from the state
    assign fsm_busy         = (state != cache_pkg::idle);
    assign mem_read         = (state == cache_pkg::request);
    assign write_data_array = (state == cache_pkg::wait_data) && memory_data_valid;
    assign write_tag_array  = (state == cache_pkg::finish);     // Last busy cycle

    // Same word address on both sides
    assign main_memory_address  = {line_base[15:2], word_cnt};
    assign cache_memory_address = {line_base[15:2], word_cnt};
    assign memory_data_out      = memory_data;                  // Written on the strobe

endmodule

// File: source/cache_data_array.sv
// Line data of the L1, read combinationally and written one word per clock
module cache_data_array (
    input  logic             clk,
    input  cache_pkg::addr_t addr,       // Index and offset select the word
    input  cache_pkg::word_t data_in,    // Processor or fill data
    input  logic             data_write, // Word write strobe
    output cache_pkg::word_t data_out    // Word at addr
);

    // 16 lines x 4 words
    cache_pkg::word_t mem [cache_pkg::NUM_LINES * cache_pkg::LINE_WORDS];

    cache_pkg::index_t  idx;
    cache_pkg::offset_t off;

    assign idx = addr[5:2];
    assign off = addr[1:0];

    always_ff @(posedge clk) begin
        if (data_write) begin
            mem[{idx, off}] <= data_in;     // Visible to a read next cycle
        end
    end

    assign data_out = mem[{idx, off}];      // Async read

endmodule

// File: source/cache_tag_array.sv
// Valid bits and tags of the L1 lines with the hit compare; tag writes come from the fill FSM
module cache_tag_array (
    input  logic            clk,
    input  logic            reset,
    input  cache_pkg::addr_t addr,      // Shared cache address
    input  logic            tag_write,  // Store tag, set valid
    output logic            hit         // Line valid and tag equal
);

    cache_pkg::tag_t   tags [cache_pkg::NUM_LINES];    // Tag per line
    logic [cache_pkg::NUM_LINES-1:0] valid;            // Valid per line

    cache_pkg::index_t idx;
    cache_pkg::tag_t   addr_tag;

    assign idx      = addr[5:2];        // Index field
    assign addr_tag = addr[15:6];       // Tag field

    // Reset clears all valid bits
    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
        end else if (tag_write) begin
            valid[idx] <= 1'b1;
        end
    end

    // Tag storage
    always_ff @(posedge clk) begin
        if (tag_write) begin
            tags[idx] <= addr_tag;
        end
    end

    // Combinational lookup, same cycle as the address
    assign hit = valid[idx] && (tags[idx] == addr_tag);

endmodule

// File: source/cache_pkg.sv
// Shared cache types, geometry and fill FSM states, referenced by scoped names from each block
package cache_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Data and address widths
    ////////////////////////////////////////////////////////////////////////////
    typedef logic [15:0] word_t;        // Processor data word
    typedef logic [15:0] addr_t;        // Word address, processor and memory side

    // Address fields of the direct-mapped L1
    typedef logic [1:0]  offset_t;      // Word in line, addr[1:0]
    typedef logic [3:0]  index_t;       // Line select, addr[5:2]
    typedef logic [9:0]  tag_t;         // Upper bits, addr[15:6]

    ////////////////////////////////////////////////////////////////////////////
    // Geometry
    ////////////////////////////////////////////////////////////////////////////
    localparam int LINE_WORDS = 4;      // Words per line
    localparam int NUM_LINES  = 16;     // Lines in the cache

    // Line fill FSM
    typedef enum logic [2:0] {
        idle,                           // Nothing in flight
        wait_grant,                     // Hold until bus grant (proceed)
        request,                        // One-cycle mem_read
        wait_data,                      // Wait for the word to come back
        finish                          // Tag and valid written here
    } fill_state_t;

endpackage
